// ==== hdl/video_pkg.sv ====
`default_nettype none

package video_pkg;

	// dram video word
	localparam int data_w = 16;
	localparam int words_per_fetch = 4; // words per fetch cycle
	localparam int pic_bytes = 8; // two bytes per word

	// dram slot timing, in clk cycles
	localparam int slot_clocks = 4; // 28 MHz / 7 MHz
	localparam int slots_per_fetch = 16;

	// derived widths
	localparam int slot_w = $clog2(slot_clocks);
	localparam int sync_w = $clog2(slots_per_fetch);
	localparam int ptr_w = $clog2(words_per_fetch);
	localparam int pic_w = pic_bytes * 8; // pixels per fetch cycle
	localparam int bit_cnt_w = $clog2(pic_w);

	// which fetch window is open
	typedef enum logic [1:0] {
		kind_none = 2'd0,
		kind_gfx = 2'd1,
		kind_tile = 2'd2,
		kind_xs = 2'd3
	} fetch_kind_t;

endpackage

`default_nettype wire

// ==== hdl/pic_if.sv ====
`default_nettype none

interface pic_if;

	logic [video_pkg::pic_bytes-1:0][7:0] pic_bits; // byte 0 is shown first
	logic pic_load; // one clk, bits valid
	video_pkg::fetch_kind_t fetch_kind; // window open at fetch_sync
	logic pic_busy; // shifter still has pixels to send

	// fetcher fills, renderer drains
	modport fetch_side (
		output pic_bits,
		output pic_load,
		output fetch_kind,
		input pic_busy
	);

	modport render_side (
		input pic_bits,
		input pic_load,
		input fetch_kind,
		output pic_busy
	);

endinterface

`default_nettype wire

// ==== hdl/dram_phase.sv ====
`default_nettype none

module dram_phase (
	input logic clk,
	input logic reset,
	output logic cend, // last clk of a 7 MHz slot
	output logic pre_cend // one clk before cend
);

	logic [video_pkg::slot_w-1:0] slot_cnt;

	// free running slot counter
	always_ff @(posedge clk)
	begin
		if (reset)
			slot_cnt <= '0;
		else if (slot_cnt == video_pkg::slot_w'(video_pkg::slot_clocks - 1))
			slot_cnt <= '0;
		else
			slot_cnt <= slot_cnt + 1'b1;
	end

	// registered decode, so compare one count early
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cend <= 1'b0;
			pre_cend <= 1'b0;
		end
		else
		begin
			cend <= (slot_cnt == video_pkg::slot_w'(video_pkg::slot_clocks - 2)); // high at 3
			pre_cend <= (slot_cnt == video_pkg::slot_w'(video_pkg::slot_clocks - 3)); // at 2
		end
	end

endmodule

`default_nettype wire

// ==== hdl/video_fetch.sv ====
`default_nettype none

module video_fetch (
	input logic clk,
	input logic reset,
	input logic cend, // dram slot strobes
	input logic pre_cend,
	input logic mode_tm, // tile mode
	input logic gfetch_start, // window pulses from raster logic
	input logic gfetch_end,
	input logic tfetch_start,
	input logic tfetch_end,
	input logic xsfetch_start,
	input logic xsfetch_end,
	input logic [video_pkg::data_w-1:0] video_data, // from arbiter
	input logic video_strobe,
	output logic video_go, // data wanted
	output logic video_gfx,
	output logic video_tile,
	output logic video_xs,
	pic_if.fetch_side pic
);

	logic [video_pkg::sync_w-1:0] fetch_sync_ctr; // slots within fetch cycle
	logic [video_pkg::ptr_w-1:0] fetch_ptr; // buffer fill pointer
	logic [video_pkg::data_w-1:0] fetch_data [video_pkg::words_per_fetch];
	logic fetch_ptr_clr;
	logic fetch_sync; // coincides with cend at count 1
	logic fetch_start; // pending counter restart
	logic sync_run; // counter idles until first start
	logic gfetch_go, tfetch_go, xsfetch_go;
	logic fetch_stop, window_rise;
	video_pkg::fetch_kind_t open_kind;

	assign gfetch_go = gfetch_start; // gfx always allowed
	assign tfetch_go = tfetch_start && mode_tm;
	assign xsfetch_go = xsfetch_start && mode_tm;
	assign fetch_stop = gfetch_end || tfetch_end || xsfetch_end; // any end closes all

	// a flag goes 0 -> 1 on this edge
	assign window_rise = !fetch_stop && ((gfetch_go && !video_gfx) ||
		(tfetch_go && !video_tile) || (xsfetch_go && !video_xs));

	assign video_go = video_gfx || video_tile || video_xs;

	// window flags, clear wins over set
	always_ff @(posedge clk)
	begin
		if (reset || fetch_stop)
		begin
			video_gfx <= 1'b0;
			video_tile <= 1'b0;
			video_xs <= 1'b0;
		end
		else
		begin
			if (gfetch_go)
				video_gfx <= 1'b1;
			if (tfetch_go)
				video_tile <= 1'b1;
			if (xsfetch_go)
				video_xs <= 1'b1;
		end
	end

	// restart request, held until the next cend
	always_ff @(posedge clk)
	begin
		if (reset)
			fetch_start <= 1'b0;
		else if (window_rise)
			fetch_start <= 1'b1;
		else if (cend)
			fetch_start <= 1'b0;
	end

	// keeps fetch_sync quiet between reset and the first start pulse
	always_ff @(posedge clk)
	begin
		if (reset)
			sync_run <= 1'b0;
		else if (gfetch_start || tfetch_start || xsfetch_start)
			sync_run <= 1'b1;
	end

	// one count per dram slot, 16 slots per fetch cycle
	always_ff @(posedge clk)
	begin
		if (reset)
			fetch_sync_ctr <= '0;
		else if (cend)
		begin
			if (fetch_start)
				fetch_sync_ctr <= '0;
			else if (sync_run)
				fetch_sync_ctr <= fetch_sync_ctr + 1'b1;
		end
	end

	// strobes decoded a clk ahead off pre_cend
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fetch_sync <= 1'b0;
			fetch_ptr_clr <= 1'b0;
			pic.pic_load <= 1'b0;
		end
		else
		begin
			fetch_sync <= pre_cend && (fetch_sync_ctr == video_pkg::sync_w'(1));
			fetch_ptr_clr <= pre_cend && (fetch_sync_ctr == '0);
			pic.pic_load <= fetch_sync; // clk after sync
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset || fetch_ptr_clr)
			fetch_ptr <= '0;
		else if (video_strobe)
			fetch_ptr <= fetch_ptr + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (video_strobe)
			fetch_data[fetch_ptr] <= video_data;
	end

	// gfx ranks first when several windows overlap
	always_comb
	begin
		if (video_gfx)
			open_kind = video_pkg::kind_gfx;
		else if (video_tile)
			open_kind = video_pkg::kind_tile;
		else if (video_xs)
			open_kind = video_pkg::kind_xs;
		else
			open_kind = video_pkg::kind_none;
	end

	// high byte goes out first
	always_ff @(posedge clk)
	begin
		if (fetch_sync)
		begin
			for (int n = 0; n < video_pkg::words_per_fetch; n++)
			begin
				pic.pic_bits[2*n] <= fetch_data[n][video_pkg::data_w-1 -: 8];
				pic.pic_bits[2*n+1] <= fetch_data[n][7:0];
			end
			pic.fetch_kind <= open_kind; // loads even with no window
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pixel_renderer.sv ====
`default_nettype none

module pixel_renderer (
	input logic clk,
	input logic reset,
	pic_if.render_side pic,
	output logic pixel, // 1 bpp serial out
	output logic pixel_valid,
	output video_pkg::fetch_kind_t kind // window of current run
);

	logic [video_pkg::pic_w-1:0] shreg; // msb is next pixel
	logic [video_pkg::bit_cnt_w-1:0] remain; // pixels left after current one
	logic busy;

	// byte 0 lands at the top, so its bit 7 leaves first
	always_ff @(posedge clk)
	begin
		if (pic.pic_load)
		begin
			for (int i = 0; i < video_pkg::pic_bytes; i++)
				shreg[video_pkg::pic_w-1-8*i -: 8] <= pic.pic_bits[i];
		end
		else if (busy)
		begin
			shreg <= {shreg[video_pkg::pic_w-2:0], 1'b0}; // one pixel per clk
		end
	end

	// run length and kind
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			remain <= '0;
			kind <= video_pkg::kind_none;
		end
		else if (pic.pic_load)
		begin
			// a load mid run drops the old pixels
			busy <= 1'b1;
			remain <= video_pkg::bit_cnt_w'(video_pkg::pic_w - 1);
			kind <= pic.fetch_kind;
		end
		else if (busy)
		begin
			if (remain == '0)
				busy <= 1'b0; // last pixel just went out
			else
				remain <= remain - 1'b1;
		end
	end

	assign pic.pic_busy = busy;
	assign pixel_valid = pic.pic_busy;
	assign pixel = shreg[video_pkg::pic_w-1];

endmodule

`default_nettype wire

// ==== hdl/video_top.sv ====
`default_nettype none

module video_top (
	input logic clk, // 28 MHz
	input logic reset,
	input logic mode_tm,
	input logic gfetch_start,
	input logic gfetch_end,
	input logic tfetch_start,
	input logic tfetch_end,
	input logic xsfetch_start,
	input logic xsfetch_end,
	input logic [video_pkg::data_w-1:0] video_data,
	input logic video_strobe,
	output logic video_go,
	output logic video_gfx,
	output logic video_tile,
	output logic video_xs,
	output logic pixel,
	output logic pixel_valid,
	output video_pkg::fetch_kind_t fetch_kind
);

	logic cend, pre_cend;

	pic_if pic_i ();

	dram_phase dram_phase_i (
		.clk (clk),
		.reset (reset),
		.cend (cend),
		.pre_cend (pre_cend)
	);

	video_fetch video_fetch_i (
		.clk (clk),
		.reset (reset),
		.cend (cend),
		.pre_cend (pre_cend),
		.mode_tm (mode_tm),
		.gfetch_start (gfetch_start),
		.gfetch_end (gfetch_end),
		.tfetch_start (tfetch_start),
		.tfetch_end (tfetch_end),
		.xsfetch_start (xsfetch_start),
		.xsfetch_end (xsfetch_end),
		.video_data (video_data),
		.video_strobe (video_strobe),
		.video_go (video_go),
		.video_gfx (video_gfx),
		.video_tile (video_tile),
		.video_xs (video_xs),
		.pic (pic_i.fetch_side)
	);

	pixel_renderer pixel_renderer_i (
		.clk (clk),
		.reset (reset),
		.pic (pic_i.render_side),
		.pixel (pixel),
		.pixel_valid (pixel_valid),
		.kind (fetch_kind)
	);

endmodule

`default_nettype wire

// ==== test/video_checker.sv ====
`default_nettype none

module video_checker (
	input logic clk,
	input logic reset,
	input logic gfetch_start, // starts tell when outputs may wake up
	input logic tfetch_start,
	input logic xsfetch_start,
	input logic video_go,
	input logic video_gfx, // window flags
	input logic video_tile,
	input logic video_xs,
	input logic pixel,
	input logic pixel_valid,
	input video_pkg::fetch_kind_t fetch_kind,
	input logic arm, // first pixel of an expected run is on the wire
	input logic [video_pkg::words_per_fetch*video_pkg::data_w-1:0] exp_bits,
	input video_pkg::fetch_kind_t exp_kind,
	input logic exp_go, // window state during the fill
	input int test_id,
	output int err_cnt,
	output int done_cnt
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [video_pkg::words_per_fetch*video_pkg::data_w-1:0] want; // msb is next pixel
	int left; // pixels still to compare
	int run_err;
	int cur_test;
	logic seen_start;
	logic streaming; // valid must never drop from here on
	logic window_shut; // end pulse given, no start since

	task automatic report_value(input string what, input int got, input int expected);
		$display("ERR %0d ns: %s, got %0d expected %0d", $time, what, got, expected);
		err_cnt++;
		run_err++;
	endtask

	task automatic report_fault(input string text);
		$display("at %0d ns: %s", $time, text);
		err_cnt++;
		run_err++;
	endtask

	task automatic finish_run();
		done_cnt++;
		if (run_err == 0)
			$display("test %0d passed, kind %s", cur_test, exp_kind.name());
		else
			$display("test %0d failed with %0d mismatches", cur_test, run_err);
	endtask

	task automatic begin_run();
		logic [2:0] exp_flags; // gfx, tile, xs
		exp_flags = {exp_kind == video_pkg::kind_gfx, exp_kind == video_pkg::kind_tile,
			exp_kind == video_pkg::kind_xs};
		run_err = 0;
		cur_test = test_id;
		if (!pixel_valid)
		begin
			report_fault($sformatf("no pixel run came out for test %0d", test_id));
			finish_run();
		end
		else
		begin
			if (fetch_kind !== exp_kind)
				report_value("fetch_kind of run", int'(fetch_kind), int'(exp_kind));
			if (video_go !== exp_go)
				report_value("video_go during fetch", int'(video_go), int'(exp_go));
			if ({video_gfx, video_tile, video_xs} !== exp_flags)
				report_value("window flags gfx tile xs during fetch",
					int'({video_gfx, video_tile, video_xs}), int'(exp_flags));
			want = exp_bits;
			left = video_pkg::pic_w;
			streaming = 1'b1;
			window_shut = 1'b1; // end pulse lands on the next edge
		end
	endtask

	task automatic check_pixel();
		if (pixel !== want[video_pkg::pic_w-1])
			report_value($sformatf("test %0d pixel %0d", cur_test, video_pkg::pic_w - left),
				int'(pixel), int'(want[video_pkg::pic_w-1]));
		if (window_shut && left < video_pkg::pic_w)
		begin
			if (video_go !== 1'b0)
				report_value("video_go after end pulse", int'(video_go), 0);
			if ({video_gfx, video_tile, video_xs} !== 3'b000)
				report_value("window flags gfx tile xs after end pulse",
					int'({video_gfx, video_tile, video_xs}), 0);
		end
		want = want << 1;
		left--;
		if (left == 0)
			finish_run();
	endtask

	// sample mid cycle, away from the clk edge
	always @(negedge clk)
	begin
		if (reset)
		begin
			err_cnt = 0;
			done_cnt = 0;
			left = 0;
			run_err = 0;
			cur_test = 0;
			seen_start = 1'b0;
			streaming = 1'b0;
			window_shut = 1'b0;
			want = '0;
		end
		else
		begin
			if (!seen_start && (pixel_valid || video_go))
			begin
				report_fault("pixel_valid or video_go went high before the first start");
				seen_start = 1'b1; // report once
			end
			if (gfetch_start || tfetch_start || xsfetch_start)
			begin
				seen_start = 1'b1;
				window_shut = 1'b0; // a new window may open
			end
			if (streaming && !pixel_valid)
			begin
				report_fault("pixel_valid dropped between back-to-back fetch cycles");
				streaming = 1'b0;
			end
			if (arm)
				begin_run();
			if (left > 0)
				check_pixel();
		end
	end

endmodule

`default_nettype wire

// ==== test/video_tb.sv ====
`default_nettype none

module video_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic reset;
	logic mode_tm;
	logic gfetch_start, gfetch_end;
	logic tfetch_start, tfetch_end;
	logic xsfetch_start, xsfetch_end;
	logic [video_pkg::data_w-1:0] video_data;
	logic video_strobe; // arbiter side, driven here
	logic video_go, video_gfx, video_tile, video_xs;
	logic pixel, pixel_valid;
	video_pkg::fetch_kind_t fetch_kind;

	logic arm; // to checker
	logic [video_pkg::words_per_fetch*video_pkg::data_w-1:0] exp_bits;
	video_pkg::fetch_kind_t exp_kind;
	logic exp_go;
	int test_id;
	int err_cnt, done_cnt;

	logic [63:0] golden [0:62]; // 7 columns per test, up to 9 tests
	int num_tests;
	int cyc; // clk edges since reset release
	int fetch_clocks = video_pkg::slot_clocks * video_pkg::slots_per_fetch;

	video_top video_top_i (
		.clk (clk),
		.reset (reset),
		.mode_tm (mode_tm),
		.gfetch_start (gfetch_start),
		.gfetch_end (gfetch_end),
		.tfetch_start (tfetch_start),
		.tfetch_end (tfetch_end),
		.xsfetch_start (xsfetch_start),
		.xsfetch_end (xsfetch_end),
		.video_data (video_data),
		.video_strobe (video_strobe),
		.video_go (video_go),
		.video_gfx (video_gfx),
		.video_tile (video_tile),
		.video_xs (video_xs),
		.pixel (pixel),
		.pixel_valid (pixel_valid),
		.fetch_kind (fetch_kind)
	);

	video_checker video_checker_i (
		.clk (clk),
		.reset (reset),
		.gfetch_start (gfetch_start),
		.tfetch_start (tfetch_start),
		.xsfetch_start (xsfetch_start),
		.video_go (video_go),
		.video_gfx (video_gfx),
		.video_tile (video_tile),
		.video_xs (video_xs),
		.pixel (pixel),
		.pixel_valid (pixel_valid),
		.fetch_kind (fetch_kind),
		.arm (arm),
		.exp_bits (exp_bits),
		.exp_kind (exp_kind),
		.exp_go (exp_go),
		.test_id (test_id),
		.err_cnt (err_cnt),
		.done_cnt (done_cnt)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 25 MHz stand-in for the 28 MHz clk
	end

	// slot position follows from the free running dram_phase
	always @(posedge clk)
	begin
		if (reset)
			cyc <= 0;
		else
			cyc <= cyc + 1; // cend is sampled on every 4th edge
	end

	// returns 2 ns after edge k
	task automatic goto_edge(input int k);
		while (cyc < k)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic drive_start(input logic [3:0] kind_code, input logic level);
		case (kind_code)
			4'd1: gfetch_start = level;
			4'd2: tfetch_start = level;
			default: xsfetch_start = level;
		endcase
	endtask

	task automatic drive_end(input int sel, input logic level);
		case (sel)
			0: gfetch_end = level;
			1: tfetch_end = level;
			default: xsfetch_end = level;
		endcase
	endtask

	// b is the cend edge where the sync counter goes to 0
	task automatic run_test(input int t, input int b);
		logic [3:0] kind_code;
		logic m;
		int r;
		r = t * 7;
		kind_code = golden[r][3:0];
		m = golden[r+1][0];
		test_id = t;
		goto_edge(b - video_pkg::slot_clocks); // start pending over the next cend
		mode_tm = m;
		drive_start(kind_code, 1'b1);
		goto_edge(b - video_pkg::slot_clocks + 1);
		drive_start(kind_code, 1'b0);
		for (int n = 0; n < video_pkg::words_per_fetch; n++)
		begin
			goto_edge(b + video_pkg::slot_clocks * (n + 5) - 1); // slot 4+n ends next edge
			video_data = golden[r+2+n][video_pkg::data_w-1:0];
			video_strobe = 1'b1;
			goto_edge(b + video_pkg::slot_clocks * (n + 5));
			video_strobe = 1'b0;
		end
		// sync at slot 1 of the next cycle, load, then the first pixel
		goto_edge(b + fetch_clocks + 2 * video_pkg::slot_clocks + 1);
		exp_bits = golden[r+6];
		if (kind_code == 4'd1 || m)
			exp_kind = video_pkg::fetch_kind_t'(kind_code[1:0]);
		else
			exp_kind = video_pkg::kind_none; // tile and xs need mode_tm
		exp_go = (exp_kind != video_pkg::kind_none);
		arm = 1'b1;
		drive_end(t % 3, 1'b1); // rotate through the end inputs
		goto_edge(b + fetch_clocks + 2 * video_pkg::slot_clocks + 2);
		arm = 1'b0;
		drive_end(t % 3, 1'b0);
	endtask

	initial
	begin
		int seed_out;
		int b;
		int gap;
		reset = 1'b1;
		mode_tm = 1'b0;
		gfetch_start = 1'b0;
		gfetch_end = 1'b0;
		tfetch_start = 1'b0;
		tfetch_end = 1'b0;
		xsfetch_start = 1'b0;
		xsfetch_end = 1'b0;
		video_data = '0;
		video_strobe = 1'b0;
		arm = 1'b0;
		exp_bits = '0;
		exp_kind = video_pkg::kind_none;
		exp_go = 1'b0;
		test_id = 0;
		seed_out = $urandom(32'h00af_5566);
		$readmemh("test/video_golden.mem", golden);
		num_tests = 0;
		while (num_tests < 9 && golden[num_tests*7][3:0] inside {4'd1, 4'd2, 4'd3})
			num_tests++;
		if (num_tests == 0)
		begin
			$display("test/video_golden.mem holds no usable test lines");
			$display("Errors found");
			$finish;
		end
		else
		begin
			repeat (16) @(posedge clk);
			#2;
			reset = 1'b0;
			b = 2 * video_pkg::slot_clocks; // first fetch cycle boundary
			for (int t = 0; t < num_tests; t++)
			begin
				run_test(t, b);
				gap = int'($urandom % 2); // idle fetch cycles
				b = b + (2 + gap) * fetch_clocks;
			end
			wait (done_cnt == num_tests);
			$display("%0d tests checked, %0d failures, seed %0h", done_cnt, err_cnt, seed_out);
			if (err_cnt == 0)
				$display("No errors");
			else
				$display("Errors found");
			$finish;
		end
	end

	// watchdog, three fetch cycles per test plus reset
	initial
	begin
		int limit;
		#1;
		limit = num_tests * 3 * fetch_clocks * 40 + 16 * 40;
		#(limit);
		$display("timeout after %0d ns, only %0d of %0d tests finished", limit, done_cnt,
			num_tests);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/video_pkg.sv
hdl/pic_if.sv
hdl/dram_phase.sv
hdl/video_fetch.sv
hdl/pixel_renderer.sv
hdl/video_top.sv
test/video_checker.sv
test/video_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -f flist.f --top-module video_tb -o video_sim > build.log 2>&1 \
	&& ./obj_dir/video_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
# verdict comes from the simulation log
grep -q "No errors" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== test/video_golden.mem ====
// columns: kind (1 gfx, 2 tile, 3 xs), mode_tm, word 0, word 1, word 2, word 3,
// expected 64 pixels with the first pixel in the msb
1 0 a5c3 0ff0 1234 8001 a5c30ff012348001
2 0 dead beef 0055 aa00 deadbeef0055aa00
2 1 ffff 0000 f00f 7e81 ffff0000f00f7e81
3 1 1357 9bdf 2468 ace0 13579bdf2468ace0
3 0 c001 d00d 4242 0bad c001d00d42420bad
1 1 8000 0001 5555 aaaa 800000015555aaaa
1 0 0000 ffff 0f0f f0f0 0000ffff0f0ff0f0
2 1 6b2d 91e4 37c8 5af0 6b2d91e437c85af0
